// ==== tests/gpio_test_stim.txt ====
// kind rnw periph reg wdata gpio_in | reply out_en out_sig intr (hex, kind 1 = next follows at once)
// kind 1 lines queue their reply and skip the output checks.
0 0 1 00 0C 0  00 C 0 0
0 0 1 01 05 0  00 C 5 0
0 1 1 00 00 0  0C C 5 0
0 1 1 01 00 0  05 C 5 0
0 0 1 01 3A 0  00 C A 0
0 1 1 01 00 0  0A C A 0
0 1 1 02 00 9  09 C A 0
0 0 1 04 0F 9  00 C A 0
0 1 1 04 00 9  00 C A 0
0 0 1 03 02 9  00 C A 0
0 0 0 00 02 9  00 C A 0
0 1 0 00 00 9  02 C A 0
0 1 1 02 00 B  0B C A 1
0 1 1 04 00 B  02 C A 1
0 1 0 01 00 B  02 C A 1
0 0 1 04 02 B  00 C A 0
0 1 5 10 00 B  FF C A 0
0 0 5 10 77 B  FF C A 0
0 1 1 07 00 B  00 C A 0
1 1 1 00 00 B  0C C A 0
0 1 1 01 00 B  0A C A 0

// ==== all.f ====
+incdir+common
common/hba_pkg.sv
serial_fpga/uart_rx.sv
serial_fpga/uart_tx.sv
serial_fpga/serial_fpga.sv
source/hba_gpio.sv
source/hba_bus.sv
source/gpio_test.sv
tests/gpio_test_tb.sv

// ==== run.sh ====
#!/usr/bin/env bash
# Build and run the testbench with Verilator from the project root.
set -e
cd "$(dirname "$0")"

verilator --binary --timing -j 0 --top-module gpio_test_tb -Mdir build -o gpio_test_sim -f all.f
./build/gpio_test_sim | tee sim.log

if grep -qx "TESTS PASSED" sim.log; then
    exit 0
fi
exit 1

// ==== tests/gpio_test_tb.sv ====
`timescale 1ns/1ps
`include "hba_config.svh"

module gpio_test_tb import hba_pkg::*; ();

    localparam int BIT_CLKS    = `CLK_FREQUENCY / `BAUD; // Clocks per serial bit.
    localparam int CLK_NS      = 20;
    localparam int COLS        = 10;  // Fields per stim line.
    localparam int MAX_LINES   = 64;
    localparam int MARGIN_BITS = 500; // Reset, idle gaps, trailing wait.

    logic                   clk;
    logic                   rst_n;
    logic                   rxd;
    logic                   txd;
    logic                   intr;
    logic [`GPIO_WIDTH-1:0] gpio_out_en;
    logic [`GPIO_WIDTH-1:0] gpio_out_sig;
    logic [`GPIO_WIDTH-1:0] gpio_in_sig;

    logic [7:0]             stim [0:MAX_LINES*COLS-1];
    logic [`DBUS_WIDTH-1:0] reply_q [$];  // Bytes seen on txd.
    logic [`DBUS_WIDTH-1:0] expect_q [$]; // Replies still owed.
    serial_cmd_t            cmd_q [$];    // Commands behind those replies.
    int                     n_lines;
    int                     reply_errs;
    int                     gpio_errs;
    int                     intr_errs;
    int                     other_errs;

    gpio_test gpio_test_i (
        .clk,
        .rst_n,
        .rxd,
        .txd,
        .intr,
        .gpio_out_en,
        .gpio_out_sig,
        .gpio_in_sig
    );

    initial begin
        clk = 1'b0;
        forever #(CLK_NS / 2) clk = ~clk;
    end

    task automatic check_reply(input logic [`DBUS_WIDTH-1:0] actual,
                               input logic [`DBUS_WIDTH-1:0] expected,
                               input serial_cmd_t c);
        if (actual !== expected) begin
            reply_errs++;
            $display("Fail at %0t ns: reply %02h, expected %02h (rnw %0d slot %0h reg %02h)",
                     $time, actual, expected, c.rnw, c.periph, c.reg_addr);
        end
    endtask

    task automatic check_gpio(input logic [`GPIO_WIDTH-1:0] actual,
                              input logic [`GPIO_WIDTH-1:0] expected, input string what);
        if (actual !== expected) begin
            gpio_errs++;
            $display("Fail at %0t ns: %s is %0h, expected %0h", $time, what, actual, expected);
        end
    endtask

    task automatic check_intr(input logic actual, input logic expected, input string what);
        if (actual !== expected) begin
            intr_errs++;
            $display("Fail at %0t ns: %s is %0b, expected %0b", $time, what, actual, expected);
        end
    endtask

    // Start, eight data bits LSB first, stop.
    task automatic send_byte(input logic [7:0] b);
        logic [9:0] frame;
        int         i;
        frame = {1'b1, b, 1'b0};
        for (i = 0; i < 10; i++) begin
            @(posedge clk);
            rxd <= frame[i];
            repeat (BIT_CLKS - 1) @(posedge clk);
        end
    endtask

    task automatic send_command(input serial_cmd_t c);
        send_byte({c.rnw, 3'b000, c.periph}); // Header.
        send_byte(c.reg_addr);
        if (!c.rnw)
            send_byte(c.wdata); // Writes only.
    endtask

    // Sampled on falling edges, away from the DUT's updates.
    task automatic receive_byte(output logic [7:0] b);
        int i;
        b = '0;
        @(negedge clk);
        while (txd !== 1'b0) @(negedge clk);
        repeat (BIT_CLKS / 2) @(negedge clk); // Middle of start bit.
        for (i = 0; i < 8; i++) begin
            repeat (BIT_CLKS) @(negedge clk);
            b[i] = txd;
        end
        repeat (BIT_CLKS) @(negedge clk);
        if (txd !== 1'b1) begin
            other_errs++;
            $display("Stop bit on txd was low at %0t ns", $time);
        end
    endtask

    initial begin : reply_monitor
        logic [7:0] b;
        wait (rst_n === 1'b1);
        forever begin
            receive_byte(b);
            reply_q.push_back(b);
        end
    end

    // Waits for every owed reply, then compares in order.
    task automatic collect_replies();
        while (reply_q.size() < expect_q.size()) @(negedge clk);
        while (expect_q.size() > 0)
            check_reply(reply_q.pop_front(), expect_q.pop_front(), cmd_q.pop_front());
    endtask

    initial begin : watchdog
        wait (rst_n === 1'b1);
        #((n_lines * 40 + MARGIN_BITS) * BIT_CLKS * CLK_NS);
        $display("Simulation timed out with replies still missing");
        $display("TESTS FAILED");
        $finish;
    end

    initial begin : main_seq
        serial_cmd_t c;
        int          base;
        int          i;
        rst_n       <= 1'b0;
        rxd         <= 1'b1; // Line idle.
        gpio_in_sig <= '0;
        reply_errs = 0;
        gpio_errs  = 0;
        intr_errs  = 0;
        other_errs = 0;
        for (i = 0; i < MAX_LINES * COLS; i++)
            stim[i] = 8'hFF; // Kind FF marks end of stimulus.
        $readmemh("tests/gpio_test_stim.txt", stim);
        n_lines = 0;
        while (n_lines < MAX_LINES && stim[n_lines*COLS] != 8'hFF) n_lines++;
        if (n_lines == 0) begin
            other_errs++;
            $display("Stimulus file tests/gpio_test_stim.txt holds no commands");
        end
        repeat (4) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_intr(txd, 1'b1, "txd after reset");
        check_intr(intr, 1'b0, "intr after reset");
        check_gpio(gpio_out_en, '0, "gpio_out_en after reset");
        check_gpio(gpio_out_sig, '0, "gpio_out_sig after reset");
        repeat (BIT_CLKS) @(posedge clk);
        for (i = 0; i < n_lines; i++) begin
            base       = i * COLS;
            c.rnw      = stim[base+1][0];
            c.periph   = stim[base+2][`PERIPH_ADDR_WIDTH-1:0];
            c.reg_addr = stim[base+3];
            c.wdata    = stim[base+4];
            @(posedge clk);
            gpio_in_sig <= stim[base+5][`GPIO_WIDTH-1:0]; // Settles long before the read.
            send_command(c);
            expect_q.push_back(stim[base+6]);
            cmd_q.push_back(c);
            if (stim[base] == 8'h00) begin // Kind 1 lets the next header overlap the reply.
                collect_replies();
                check_gpio(gpio_out_en, stim[base+7][`GPIO_WIDTH-1:0], "gpio_out_en");
                check_gpio(gpio_out_sig, stim[base+8][`GPIO_WIDTH-1:0], "gpio_out_sig");
                check_intr(intr, stim[base+9][0], "intr");
            end
        end
        collect_replies();
        repeat (12 * BIT_CLKS) @(posedge clk); // Catch stray bytes.
        if (reply_q.size() != 0) begin
            other_errs++;
            $display("Got %0d reply bytes on txd that no command asked for", reply_q.size());
        end
        $display("Errors: reply %0d, gpio %0d, intr %0d, other %0d",
                 reply_errs, gpio_errs, intr_errs, other_errs);
        if (reply_errs + gpio_errs + intr_errs + other_errs == 0)
            $display("TESTS PASSED");
        else
            $display("TESTS FAILED");
        $finish;
    end

endmodule

// ==== source/gpio_test.sv ====
`timescale 1ns/1ps
`include "hba_config.svh"

module gpio_test import hba_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   rxd,
    output logic                   txd,
    output logic                   intr,
    output logic [`GPIO_WIDTH-1:0] gpio_out_en,
    output logic [`GPIO_WIDTH-1:0] gpio_out_sig,
    input  logic [`GPIO_WIDTH-1:0] gpio_in_sig
);

    hba_req_t req_master; // From the serial master.
    hba_req_t req;        // Combined, to all slaves.
    hba_rsp_t rsp_serial; // Slot 0.
    hba_rsp_t rsp_gpio;   // Slot 1.
    hba_rsp_t rsp;        // Combined, back to master.
    logic     mrequest;
    logic     mgrant;
    logic     gpio_interrupt;

    serial_fpga serial_fpga_inst (
        .clk,
        .rst_n,
        .rxd,
        .txd,
        .intr,
        .slave_interrupt(gpio_interrupt),
        .mrequest,
        .mgrant,
        .req_master,
        .req,
        .rsp,
        .rsp_slave(rsp_serial)
    );

    hba_gpio hba_gpio_inst (
        .clk,
        .rst_n,
        .req,
        .rsp(rsp_gpio),
        .slave_interrupt(gpio_interrupt),
        .gpio_out_en,
        .gpio_out_sig,
        .gpio_in_sig
    );

    hba_bus hba_bus_inst (
        .clk,
        .rst_n,
        .mrequest,
        .mgrant,
        .req_master,
        .rsp_serial,
        .rsp_gpio,
        .req,
        .rsp
    );

endmodule

// ==== source/hba_bus.sv ====
`timescale 1ns/1ps
`include "hba_config.svh"

module hba_bus import hba_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     mrequest,
    output logic     mgrant,
    input  hba_req_t req_master,
    input  hba_rsp_t rsp_serial,
    input  hba_rsp_t rsp_gpio,
    output hba_req_t req,
    output hba_rsp_t rsp
);

    localparam int TO_W = $clog2(`XFER_TIMEOUT + 1);
    localparam logic [TO_W-1:0] TO_LAST = TO_W'(`XFER_TIMEOUT);

    logic [TO_W-1:0] to_cnt;    // Select cycles without an ack.
    logic            slave_ack;
    logic            to_ack;    // Bus answers for a missing slave.
    hba_rsp_t        rsp_to;

    // Grant follows request one cycle later. Only master, so select is always its own.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            mgrant <= 1'b0;
        else
            mgrant <= mrequest;
    end

    // Single master. Ungranted master contributes nothing.
    assign req = mgrant ? req_master : '0;

    assign slave_ack = rsp_serial.xferack | rsp_gpio.xferack;
    assign to_ack    = req.select && !slave_ack && (to_cnt == TO_LAST);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            to_cnt <= '0;
        else if (req.select && !slave_ack && !to_ack)
            to_cnt <= to_cnt + 1'b1;
        else
            to_cnt <= '0; // Idle or acked.
    end

    always_comb begin
        rsp_to = '0;
        if (to_ack) begin
            rsp_to.xferack = 1'b1;
            rsp_to.dbus    = '1; // FF marks no slave.
        end
    end

    // Inactive slaves drive zero so OR merges them.
    assign rsp = rsp_serial | rsp_gpio | rsp_to;

endmodule

// ==== source/hba_gpio.sv ====
`timescale 1ns/1ps
`include "hba_config.svh"

module hba_gpio import hba_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  hba_req_t               req,
    output hba_rsp_t               rsp,
    output logic                   slave_interrupt,
    output logic [`GPIO_WIDTH-1:0] gpio_out_en,
    output logic [`GPIO_WIDTH-1:0] gpio_out_sig,
    input  logic [`GPIO_WIDTH-1:0] gpio_in_sig
);

    localparam logic [`PERIPH_ADDR_WIDTH-1:0] SLOT =
        `PERIPH_ADDR_WIDTH'(`GPIO_PERIPH_ADDR);
    localparam int PAD_W = `DBUS_WIDTH - `GPIO_WIDTH;

    logic [`GPIO_WIDTH-1:0]     in_meta;   // First sync stage.
    logic [`GPIO_WIDTH-1:0]     in_sync;   // Reg 2.
    logic [`GPIO_WIDTH-1:0]     in_prev;   // For edge detect.
    logic [`GPIO_WIDTH-1:0]     int_en;    // Reg 3.
    logic [`GPIO_WIDTH-1:0]     int_stat;  // Reg 4.
    logic [`GPIO_WIDTH-1:0]     stat_clr;
    logic [`GPIO_WIDTH-1:0]     wr_bits;
    logic                       sel_me;
    logic                       wr_en;
    logic [`REG_ADDR_WIDTH-1:0] reg_sel;

    assign sel_me   = req.select && (req.abus[`ADDR_WIDTH-1:`REG_ADDR_WIDTH] == SLOT);
    assign reg_sel  = req.abus[`REG_ADDR_WIDTH-1:0];
    assign wr_bits  = req.dbus[`GPIO_WIDTH-1:0];
    assign wr_en    = sel_me && !rsp.xferack && !req.rnw; // Once per transfer.
    assign stat_clr = (wr_en && reg_sel == 8'd4) ? wr_bits : '0; // Write 1 to clear.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            in_meta      <= '0;
            in_sync      <= '0;
            in_prev      <= '0;
            gpio_out_en  <= '0;
            gpio_out_sig <= '0;
            int_en       <= '0;
            int_stat     <= '0;
            rsp          <= '0;
        end else begin
            in_meta  <= gpio_in_sig;
            in_sync  <= in_meta;
            in_prev  <= in_sync;
            int_stat <= (int_stat & ~stat_clr) | (in_sync & ~in_prev); // Rising edges set.
            rsp      <= '0; // Dbus zero outside the ack.
            if (sel_me && !rsp.xferack) begin
                rsp.xferack <= 1'b1;
                if (req.rnw) begin
                    case (reg_sel)
                        8'd0: rsp.dbus <= {{PAD_W{1'b0}}, gpio_out_en};
                        8'd1: rsp.dbus <= {{PAD_W{1'b0}}, gpio_out_sig};
                        8'd2: rsp.dbus <= {{PAD_W{1'b0}}, in_sync};
                        8'd3: rsp.dbus <= {{PAD_W{1'b0}}, int_en};
                        8'd4: rsp.dbus <= {{PAD_W{1'b0}}, int_stat};
                        default: rsp.dbus <= '0; // Unused regs still ack.
                    endcase
                end
            end
            if (wr_en) begin
                case (reg_sel)
                    8'd0: gpio_out_en <= wr_bits;
                    8'd1: gpio_out_sig <= wr_bits;
                    8'd3: int_en <= wr_bits;
                    default: ; // Reg 2 read-only. Reg 4 handled above.
                endcase
            end
        end
    end

    assign slave_interrupt = |(int_stat & int_en);

endmodule

// ==== serial_fpga/serial_fpga.sv ====
`timescale 1ns/1ps
`include "hba_config.svh"

module serial_fpga import hba_pkg::*; (
    input  logic     clk,
    input  logic     rst_n,
    input  logic     rxd,
    output logic     txd,
    output logic     intr,
    input  logic     slave_interrupt,
    output logic     mrequest,
    input  logic     mgrant,
    output hba_req_t req_master,
    input  hba_req_t req,
    input  hba_rsp_t rsp,
    output hba_rsp_t rsp_slave
);

    typedef enum logic [2:0] {S_HDR, S_REG, S_DATA, S_HOLD, S_REQ, S_XFER} state_t;

    localparam logic [`PERIPH_ADDR_WIDTH-1:0] SLOT =
        `PERIPH_ADDR_WIDTH'(`SERIAL_PERIPH_ADDR);

    state_t                    state;
    serial_cmd_t               cmd;
    logic [7:0]                rx_data;
    logic                      rx_valid;
    logic [7:0]                tx_data;  // Reply byte.
    logic                      tx_load;  // One-cycle strobe.
    logic                      tx_busy;
    logic [`DBUS_WIDTH-1:0]    int_en;   // Slave reg 0.
    logic [`DBUS_WIDTH-1:0]    pending;  // Slave reg 1. Bit n follows slot n.
    logic                      sel_me;
    logic [`REG_ADDR_WIDTH-1:0] reg_sel;

    uart_rx uart_rx_inst (.clk, .rst_n, .rxd, .data(rx_data), .valid(rx_valid));
    uart_tx uart_tx_inst (.clk, .rst_n, .data(tx_data), .load(tx_load), .txd, .busy(tx_busy));

    // Parser and bus master.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= S_HDR;
            tx_load <= 1'b0;
        end else begin
            tx_load <= 1'b0;
            case (state)
                S_HDR: if (rx_valid) state <= S_REG;
                S_REG: if (rx_valid) state <= cmd.rnw ? S_HOLD : S_DATA;
                S_DATA: if (rx_valid) state <= S_HOLD;
                S_HOLD: if (!tx_busy) state <= S_REQ; // Previous reply still going.
                S_REQ: if (mgrant) state <= S_XFER;
                S_XFER: begin
                    if (rsp.xferack) begin
                        tx_load <= 1'b1; // Write ack carries 00, timeout FF.
                        state   <= S_HDR;
                    end
                end
                default: state <= S_HDR;
            endcase
        end
    end

    // Command and reply bytes are payload.
    always_ff @(posedge clk) begin
        if (rx_valid) begin
            case (state)
                S_HDR: begin
                    cmd.rnw    <= rx_data[7];
                    cmd.periph <= rx_data[`PERIPH_ADDR_WIDTH-1:0];
                    cmd.wdata  <= '0; // Reads drive no data.
                end
                S_REG: cmd.reg_addr <= rx_data;
                S_DATA: cmd.wdata <= rx_data;
                default: ; // Bytes while busy are dropped.
            endcase
        end
        if (state == S_XFER && rsp.xferack)
            tx_data <= rsp.dbus;
    end

    assign mrequest = (state == S_REQ) || (state == S_XFER);

    // Zero unless a transfer is running.
    always_comb begin
        req_master = '0;
        if (state == S_XFER) begin
            req_master.select = 1'b1;
            req_master.rnw    = cmd.rnw;
            req_master.abus   = {cmd.periph, cmd.reg_addr};
            req_master.dbus   = cmd.wdata;
        end
    end

    // Own register slot.
    assign sel_me  = req.select && (req.abus[`ADDR_WIDTH-1:`REG_ADDR_WIDTH] == SLOT);
    assign reg_sel = req.abus[`REG_ADDR_WIDTH-1:0];
    assign pending = `DBUS_WIDTH'(slave_interrupt) << `GPIO_PERIPH_ADDR;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            int_en    <= '0;
            rsp_slave <= '0;
        end else begin
            rsp_slave <= '0; // Ack lasts one cycle.
            if (sel_me && !rsp_slave.xferack) begin
                rsp_slave.xferack <= 1'b1;
                if (req.rnw) begin
                    case (reg_sel)
                        8'd0: rsp_slave.dbus <= int_en;
                        8'd1: rsp_slave.dbus <= pending;
                        default: rsp_slave.dbus <= '0;
                    endcase
                end else if (reg_sel == 8'd0) begin
                    int_en <= req.dbus;
                end
            end
        end
    end

    assign intr = |(int_en & pending); // Enabled slot interrupts.

endmodule

// ==== serial_fpga/uart_tx.sv ====
`timescale 1ns/1ps
`include "hba_config.svh"

module uart_tx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic [7:0] data,
    input  logic       load,
    output logic       txd,
    output logic       busy
);

    localparam int BIT_CLKS = `CLK_FREQUENCY / `BAUD;
    localparam int CNT_W    = $clog2(BIT_CLKS);
    localparam logic [CNT_W-1:0] BIT_LAST = CNT_W'(BIT_CLKS - 1);

    logic [9:0]       shift;   // Stop, data, start. LSB goes out first.
    logic [CNT_W-1:0] clk_cnt; // Clocks left in current bit.
    logic [3:0]       bit_cnt; // Bits already sent.

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            shift   <= '1; // Idle line high.
            busy    <= 1'b0;
            clk_cnt <= '0;
            bit_cnt <= '0;
        end else if (load && !busy) begin
            shift   <= {1'b1, data, 1'b0}; // Framed byte.
            busy    <= 1'b1;
            clk_cnt <= BIT_LAST;
            bit_cnt <= '0;
        end else if (busy) begin
            if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= BIT_LAST;
                shift   <= {1'b1, shift[9:1]}; // Back-fill with idle level.
                if (bit_cnt == 4'd9)
                    busy <= 1'b0; // Stop bit done.
                else
                    bit_cnt <= bit_cnt + 1'b1;
            end
        end
    end

    assign txd = shift[0];

endmodule

// ==== serial_fpga/uart_rx.sv ====
`timescale 1ns/1ps
`include "hba_config.svh"

module uart_rx (
    input  logic       clk,
    input  logic       rst_n,
    input  logic       rxd,
    output logic [7:0] data,
    output logic       valid
);

    localparam int BIT_CLKS = `CLK_FREQUENCY / `BAUD;
    localparam int CNT_W    = $clog2(BIT_CLKS);
    localparam logic [CNT_W-1:0] BIT_LAST  = CNT_W'(BIT_CLKS - 1);
    localparam logic [CNT_W-1:0] HALF_LAST = CNT_W'(BIT_CLKS / 2 - 1);

    logic [1:0]       rxd_sync; // Two-flop synchronizer.
    logic             busy;     // Inside a frame.
    logic [CNT_W-1:0] clk_cnt;  // Clocks to next sample point.
    logic [3:0]       bit_cnt;  // 0 start, 1..8 data, 9 stop.
    logic [7:0]       shift;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            rxd_sync <= 2'b11; // Line idles high.
            busy     <= 1'b0;
            clk_cnt  <= '0;
            bit_cnt  <= '0;
            valid    <= 1'b0;
        end else begin
            rxd_sync <= {rxd_sync[0], rxd};
            valid    <= 1'b0;
            if (!busy) begin
                if (!rxd_sync[1]) begin // Start edge.
                    busy    <= 1'b1;
                    clk_cnt <= HALF_LAST; // First sample mid start bit.
                    bit_cnt <= '0;
                end
            end else if (clk_cnt != '0) begin
                clk_cnt <= clk_cnt - 1'b1;
            end else begin
                clk_cnt <= BIT_LAST;
                bit_cnt <= bit_cnt + 1'b1;
                if (bit_cnt == 4'd0) begin
                    if (rxd_sync[1]) busy <= 1'b0; // Glitch, not a start bit.
                end else if (bit_cnt == 4'd9) begin
                    busy  <= 1'b0;
                    valid <= rxd_sync[1]; // Bad stop bit drops the byte.
                end
            end
        end
    end

    // Data bits arrive LSB first.
    always_ff @(posedge clk) begin
        if (busy && clk_cnt == '0 && bit_cnt != 4'd0 && bit_cnt != 4'd9)
            shift <= {rxd_sync[1], shift[7:1]};
    end

    assign data = shift;

endmodule

// ==== common/hba_pkg.sv ====
`include "hba_config.svh"

package hba_pkg;

    // Master side of the bus. All zero while the master is idle.
    typedef struct packed {
        logic                   select; // Transfer in progress.
        logic                   rnw;    // 1 reads, 0 writes.
        logic [`ADDR_WIDTH-1:0] abus;   // Peripheral then register.
        logic [`DBUS_WIDTH-1:0] dbus;   // Write data.
    } hba_req_t;

    // Slave side of the bus. Zero except in the ack cycle.
    typedef struct packed {
        logic                   xferack; // One cycle per transfer.
        logic [`DBUS_WIDTH-1:0] dbus;    // Read data.
    } hba_rsp_t;

    // Command assembled from the serial bytes.
    typedef struct packed {
        logic                          rnw;      // From header bit 7.
        logic [`PERIPH_ADDR_WIDTH-1:0] periph;   // From header bits 3:0.
        logic [`REG_ADDR_WIDTH-1:0]    reg_addr; // Second byte.
        logic [`DBUS_WIDTH-1:0]        wdata;    // Third byte, writes only.
    } serial_cmd_t;

endpackage

// ==== common/hba_config.svh ====
`ifndef HBA_CONFIG_SVH
`define HBA_CONFIG_SVH

// System clock in Hz.
`define CLK_FREQUENCY 50_000_000
// Serial bit rate. Ten clocks per bit.
`define BAUD 5_000_000

// Bus data width.
`define DBUS_WIDTH 8
// Upper address field selects the peripheral.
`define PERIPH_ADDR_WIDTH 4
// Lower address field selects the register.
`define REG_ADDR_WIDTH 8
`define ADDR_WIDTH (`PERIPH_ADDR_WIDTH + `REG_ADDR_WIDTH)

// Slot of the serial master's own registers.
`define SERIAL_PERIPH_ADDR 0
// Slot of the GPIO block.
`define GPIO_PERIPH_ADDR 1
// Pins per GPIO vector.
`define GPIO_WIDTH 4

// Select cycles before the bus answers on its own.
`define XFER_TIMEOUT 15

`endif
